//--- daTop.f
+incdir+design
+incdir+dv
design/daPkg.sv
design/daLut.sv
design/daDecode.sv
design/daExecute.sv
design/daResult.sv
design/daTop.sv
dv/tbTop.sv

//--- design/daCfg.svh
`ifndef DA_CFG_SVH
`define DA_CFG_SVH

// Fixed-point format, value width is DA_N_INT + DA_N_MANT + 1 with sign
`define DA_N_INT 8
`define DA_N_MANT 8
`define DA_N_TOT (`DA_N_INT + `DA_N_MANT)

// Select vector and lookup-table split
`define DA_SIZE 12
`define DA_LUT_SIZE 4
`define DA_LUT_NUM (`DA_SIZE / `DA_LUT_SIZE)

// Buffer depths, also the starting credit counts
`define DA_CMD_DEPTH 4
`define DA_RSP_DEPTH 4

`define DA_TAG_W 4

// Coefficient j is (j+1)/4, i.e. raw (j+1) << 6 with 8 fraction bits
`define DA_COEF(j) (((j) + 1) << (`DA_N_MANT - 2))

`endif

//--- design/daDecode.sv
`timescale 1ns/1ps
`include "daCfg.svh"

module daDecode (
    input  logic            clk,
    input  logic            rst,
    input  logic            cmdValid,
    input  daPkg::daCmd_t   cmd,
    output logic            cmdCredit,
    input  logic            freeCredit,
    output daPkg::daIssue_t issue
);
    import daPkg::*;

    localparam int PtrW  = $clog2(`DA_CMD_DEPTH);
    localparam int CredW = $clog2(`DA_RSP_DEPTH) + 1;

    daCmd_t           cmdMem [`DA_CMD_DEPTH];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [PtrW:0]    count;
    logic [CredW-1:0] rspCredits;  // Free slots in the result buffer
    logic             doIssue;
    logic             issueValid;
    daCmd_t           issueCmd;

    assign doIssue = (count != '0) && (rspCredits != '0);

    always_ff @(posedge clk) begin
        if (cmdValid) begin
            cmdMem[wrPtr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (cmdValid) wrPtr <= wrPtr + 1'b1;
            if (doIssue) rdPtr <= rdPtr + 1'b1;
            case ({cmdValid, doIssue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rspCredits <= CredW'(`DA_RSP_DEPTH);
        end else begin
            case ({freeCredit, doIssue})
                2'b10:   rspCredits <= rspCredits + 1'b1;
                2'b01:   rspCredits <= rspCredits - 1'b1;
                default: rspCredits <= rspCredits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issueValid <= 1'b0;
            cmdCredit  <= 1'b0;
        end else begin
            issueValid <= doIssue;
            cmdCredit  <= doIssue;  // Slot freed, hand credit back upstream
        end
    end

    always_ff @(posedge clk) begin
        if (doIssue) begin
            issueCmd <= cmdMem[rdPtr];
        end
    end

    assign issue = '{valid: issueValid, op: issueCmd.op, sel: issueCmd.sel, tag: issueCmd.tag};

endmodule

//--- design/daExecute.sv
`timescale 1ns/1ps
`include "daCfg.svh"

module daExecute (
    input  logic            clk,
    input  logic            rst,
    input  daPkg::daIssue_t issue,
    output logic            execValid,
    output daPkg::daRsp_t   exec
);
    import daPkg::*;

    localparam int Stages = 4;  // LUT, adder 0, adder 1, accumulate

    daFix_t               lutOut [`DA_LUT_NUM];
    daFix_t               lutReg [`DA_LUT_NUM];
    daFix_t               sum01;
    daFix_t               pass2;
    daFix_t               sumReg;
    daFix_t               acc;
    daFix_t               accNext;
    daFix_t               execValue;
    logic [Stages-1:0]    stageValid;
    daOp_e                stageOp  [Stages];
    logic [`DA_TAG_W-1:0] stageTag [Stages];

    for (genvar i = 0; i < `DA_LUT_NUM; i++) begin : genLut
        daLut #(
            .lutBits (`DA_LUT_SIZE),
            .base    (i * `DA_LUT_SIZE)
        ) i_daLut (
            .sel    (issue.sel[i*`DA_LUT_SIZE +: `DA_LUT_SIZE]),
            .result (lutOut[i])
        );
    end

    // Datapath registers, valid travels in stageValid
    always_ff @(posedge clk) begin
        for (int i = 0; i < `DA_LUT_NUM; i++) begin
            lutReg[i] <= lutOut[i];
        end
        sum01  <= lutReg[0] + lutReg[1];
        pass2  <= lutReg[2];  // Odd table skips layer 0
        sumReg <= sum01 + pass2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[Stages-2:0], issue.valid};
        end
    end

    always_ff @(posedge clk) begin
        stageOp[0]  <= issue.op;
        stageTag[0] <= issue.tag;
        for (int s = 1; s < Stages; s++) begin
            stageOp[s]  <= stageOp[s-1];
            stageTag[s] <= stageTag[s-1];
        end
    end

    always_comb begin
        case (stageOp[Stages-2])
            OP_MAC:  accNext = acc + sumReg;  // Wraps in two's complement
            OP_CLR:  accNext = '0;
            default: accNext = acc;
        endcase
    end

    // Ops reach this stage in issue order, so the accumulator stays ordered
    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (stageValid[Stages-2]) begin
            acc <= accNext;
        end
    end

    always_ff @(posedge clk) begin
        if (stageOp[Stages-2] == OP_DOT) begin
            execValue <= sumReg;
        end else begin
            execValue <= accNext;
        end
    end

    assign execValid = stageValid[Stages-1];
    assign exec      = '{op: stageOp[Stages-1], tag: stageTag[Stages-1], value: execValue};

endmodule

//--- design/daLut.sv
`timescale 1ns/1ps
`include "daCfg.svh"

module daLut #(
    parameter int lutBits = `DA_LUT_SIZE,
    parameter int base    = 0
) (
    input  logic [lutBits-1:0] sel,
    output daPkg::daFix_t      result
);
    import daPkg::*;

    localparam int Entries = 2 ** lutBits;

    daFix_t lutMem [Entries];

    // Signed sum of the slice: +coef where the bit is set, -coef otherwise
    function automatic daFix_t lutEntry(int pattern);
        daFix_t acc;
        acc = '0;
        for (int j = 0; j < lutBits; j++) begin
            if (pattern[j]) begin
                acc = acc + daFix_t'(`DA_COEF(base + j));
            end else begin
                acc = acc - daFix_t'(`DA_COEF(base + j));
            end
        end
        return acc;
    endfunction

    for (genvar i = 0; i < Entries; i++) begin : genEntry
        assign lutMem[i] = lutEntry(i);  // Constant at elaboration
    end

    assign result = lutMem[sel];

endmodule

//--- design/daPkg.sv
`include "daCfg.svh"

package daPkg;

    // Signed fixed point, sign + DA_N_INT integer + DA_N_MANT fraction bits
    typedef logic signed [`DA_N_TOT:0] daFix_t;

    typedef enum logic [1:0] {
        OP_DOT = 2'd0,  // Result is the coefficient sum
        OP_MAC = 2'd1,  // Accumulate sum, return new accumulator
        OP_CLR = 2'd2   // Clear accumulator, return zero
    } daOp_e;

    typedef struct packed {
        daOp_e                op;
        logic [`DA_SIZE-1:0]  sel;
        logic [`DA_TAG_W-1:0] tag;
    } daCmd_t;

    typedef struct packed {
        logic                 valid;
        daOp_e                op;
        logic [`DA_SIZE-1:0]  sel;
        logic [`DA_TAG_W-1:0] tag;
    } daIssue_t;

    typedef struct packed {
        daOp_e                op;
        logic [`DA_TAG_W-1:0] tag;
        daFix_t               value;
    } daRsp_t;

endpackage

//--- design/daResult.sv
`timescale 1ns/1ps
`include "daCfg.svh"

module daResult (
    input  logic          clk,
    input  logic          rst,
    input  logic          execValid,
    input  daPkg::daRsp_t exec,
    input  logic          rspCredit,
    output logic          rspValid,
    output daPkg::daRsp_t rsp,
    output logic          freeCredit
);
    import daPkg::*;

    localparam int PtrW  = $clog2(`DA_RSP_DEPTH);
    localparam int CredW = 8;

    daRsp_t           rspMem [`DA_RSP_DEPTH];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [PtrW:0]    count;
    logic [CredW-1:0] credits;  // Downstream slots granted
    logic             sendNow;

    assign sendNow = (count != '0) && (credits != '0);

    // Decode only issues against free slots, so a write never hits a full buffer
    always_ff @(posedge clk) begin
        if (execValid) begin
            rspMem[wrPtr] <= exec;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            credits <= '0;
        end else begin
            if (execValid) wrPtr <= wrPtr + 1'b1;
            if (sendNow) rdPtr <= rdPtr + 1'b1;
            case ({execValid, sendNow})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (rspCredit && !sendNow && credits != '1) begin
                credits <= credits + 1'b1;  // Saturates
            end else if (!rspCredit && sendNow) begin
                credits <= credits - 1'b1;
            end
        end
    end

    assign rspValid   = sendNow;
    assign rsp        = rspMem[rdPtr];
    assign freeCredit = sendNow;  // Slot reused, tell decode

endmodule

//--- design/daTop.sv
`timescale 1ns/1ps

module daTop (
    input  logic          clk,
    input  logic          rst,
    input  logic          cmdValid,
    input  daPkg::daCmd_t cmd,
    output logic          cmdCredit,
    input  logic          rspCredit,
    output logic          rspValid,
    output daPkg::daRsp_t rsp
);
    import daPkg::*;

    daIssue_t issue;
    logic     execValid;
    daRsp_t   exec;
    logic     freeCredit;

    daDecode i_daDecode (
        .clk        (clk),
        .rst        (rst),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .cmdCredit  (cmdCredit),
        .freeCredit (freeCredit),
        .issue      (issue)
    );

    daExecute i_daExecute (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .execValid (execValid),
        .exec      (exec)
    );

    daResult i_daResult (
        .clk        (clk),
        .rst        (rst),
        .execValid  (execValid),
        .exec       (exec),
        .rspCredit  (rspCredit),
        .rspValid   (rspValid),
        .rsp        (rsp),
        .freeCredit (freeCredit)
    );

endmodule

//--- dv/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Signed sum written as twice the selected coefficients minus all of them
function automatic int coefSum(input logic [`DA_SIZE-1:0] sel);
    int total;
    int picked;
    total  = 0;
    picked = 0;
    for (int j = 0; j < `DA_SIZE; j++) begin
        total += `DA_COEF(j);
        if (sel[j]) begin
            picked += `DA_COEF(j);
        end
    end
    return 2 * picked - total;
endfunction

// Expected response value, acc follows the accumulator in command order
function automatic daFix_t modelStep(input daOp_e op, input logic [`DA_SIZE-1:0] sel,
                                     inout daFix_t acc);
    daFix_t value;
    case (op)
        OP_MAC: begin
            acc   = daFix_t'(int'(acc) + coefSum(sel));  // Truncation wraps at 17 bits
            value = acc;
        end
        OP_CLR: begin
            acc   = '0;
            value = '0;
        end
        default: value = daFix_t'(coefSum(sel));
    endcase
    return value;
endfunction

`endif

//--- dv/tbTop.sv
`timescale 1ns/1ps
`include "daCfg.svh"

module tbTop;
    import daPkg::*;
    `include "tbModel.svh"

    localparam int WaitLimit = 500;

    logic   clk;
    logic   rst;
    logic   cmdValid;
    daCmd_t cmd;
    logic   cmdCredit;
    logic   rspCredit;
    logic   rspValid;
    daRsp_t rsp;

    int                   cmdCredits = `DA_CMD_DEPTH;
    int                   grantAvail = 0;  // Granted response credits not yet used
    int                   holdLeft   = 0;
    bit                   forceHold  = 0;
    bit                   quiet      = 1;
    daRsp_t               expQ [$];
    daRsp_t               expRsp;
    daFix_t               modelAcc   = '0;
    logic [`DA_TAG_W-1:0] nextTag    = '0;
    string                testName   = "reset";

    daTop i_daTop (
        .clk       (clk),
        .rst       (rst),
        .cmdValid  (cmdValid),
        .cmd       (cmd),
        .cmdCredit (cmdCredit),
        .rspCredit (rspCredit),
        .rspValid  (rspValid),
        .rsp       (rsp)
    );

    always #20 clk = ~clk;

    task automatic stopRun(input string why);
        if (why != "") begin
            $display("ERROR: %s", why);
        end
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkOp(input string name, input daOp_e exp, input daOp_e act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected op %s, actual op %s",
                     name, exp.name(), act.name());
            stopRun("");
        end
    endtask

    task automatic checkRsp(input string name, input daRsp_t exp, input daRsp_t act);
        if (exp.tag !== act.tag || exp.value !== act.value) begin
            $display("CHECK FAILED %s: expected tag %0d value %0d, actual tag %0d value %0d",
                     name, exp.tag, exp.value, act.tag, act.value);
            stopRun("");
        end
    endtask

    // One clock with response credits granted at random in bursts
    task automatic stepCycle(input logic sendCmd, input daCmd_t c);
        logic grant;
        grant = 1'b0;
        @(posedge clk);
        if (holdLeft > 0) begin
            holdLeft--;
        end else if (!forceHold && grantAvail < 8) begin
            grant = ($urandom_range(3) != 0);
            if ($urandom_range(39) == 0) holdLeft = 4 + $urandom_range(15);
        end
        cmdValid  <= sendCmd;
        cmd       <= c;
        rspCredit <= grant;
    endtask

    task automatic sendCommand(input daOp_e op, input logic [`DA_SIZE-1:0] sel);
        daRsp_t exp;
        int     waited;
        waited = 0;
        while (cmdCredits == 0 && waited < WaitLimit) begin
            stepCycle(1'b0, '0);
            waited++;
        end
        if (cmdCredits == 0) begin
            stopRun("timed out waiting for a command credit");
        end else begin
            exp = '{op: op, tag: nextTag, value: modelStep(op, sel, modelAcc)};
            expQ.push_back(exp);
            cmdCredits--;
            stepCycle(1'b1, '{op: op, sel: sel, tag: nextTag});
            nextTag++;
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while ((expQ.size() != 0 || cmdCredits != `DA_CMD_DEPTH) && waited < WaitLimit) begin
            stepCycle(1'b0, '0);
            waited++;
        end
        if (expQ.size() != 0) begin
            stopRun("timed out waiting for outstanding responses");
        end else if (cmdCredits != `DA_CMD_DEPTH) begin
            stopRun("command credits did not return to the command buffer depth");
        end
    endtask

    // Outputs sampled half a cycle after the edge that changes them
    always @(negedge clk) begin
        if (rst || quiet) begin
            if (rspValid || cmdCredit) stopRun("rspValid or cmdCredit high around reset");
        end else begin
            if (cmdCredit) cmdCredits++;
            if (cmdCredits > `DA_CMD_DEPTH) begin
                stopRun("more command credits returned than were used");
            end else if (rspValid && grantAvail == 0) begin
                stopRun("rspValid rose without a granted response credit");
            end else if (rspValid && expQ.size() == 0) begin
                stopRun("response arrived with no command outstanding");
            end else if (rspValid) begin
                grantAvail--;
                expRsp = expQ.pop_front();
                checkOp(testName, expRsp.op, rsp.op);
                checkRsp(testName, expRsp, rsp);
            end
        end
        if (!rst && rspCredit) grantAvail++;  // DUT counts it at the next edge
    end

    initial begin
        int sent;
        void'($urandom(32'hcedc_6cb2));
        clk       = 1'b0;
        rst       = 1'b1;
        cmdValid  = 1'b0;
        cmd       = '0;
        rspCredit = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (5) stepCycle(1'b0, '0);
        quiet = 0;

        testName = "macFirst";
        sendCommand(OP_MAC, `DA_SIZE'($urandom));
        waitDrain();

        testName = "dotRandom";
        repeat (60) sendCommand(OP_DOT, `DA_SIZE'($urandom));

        testName = "macWrap";
        repeat (30) sendCommand(OP_MAC, '1);

        testName = "clear";
        sendCommand(OP_CLR, `DA_SIZE'($urandom));
        sendCommand(OP_MAC, `DA_SIZE'($urandom));
        waitDrain();

        testName  = "backpressure";
        forceHold = 1;
        sent      = 0;
        while (cmdCredits > 0 && sent < WaitLimit) begin
            sendCommand(OP_DOT, `DA_SIZE'($urandom));
            sent++;
        end
        if (cmdCredits > 0) begin
            stopRun("command credits kept returning while response credits were withheld");
        end
        repeat (40) stepCycle(1'b0, '0);
        if (expQ.size() == 0) stopRun("no responses were held back while credits were withheld");
        forceHold = 0;
        waitDrain();

        testName = "mixed";
        repeat (150) sendCommand(daOp_e'($urandom_range(2)), `DA_SIZE'($urandom));
        waitDrain();

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbTop -f daTop.f --Mdir obj_dir -o tbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tbSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0
